//--- build.f
+incdir+include
verilog/sema_pkg.sv
verilog/sema_axil_slave.sv
verilog/sema_array.sv
verilog/sema_top.sv
sim/sema_clk_gen.sv
sim/sema_chk.sv
sim/sema_tb.sv

//--- Makefile
# Verilator flow for the AXI4-Lite semaphore bank
TOP := sema_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/sema_tb.sv
`timescale 1ns/1ns
`include "sema_macros.svh"

module sema_tb;

	// One directed step, exp is only used by reads
	typedef struct packed {
		logic                 wr;
		sema_pkg::axil_addr_t addr;
		sema_pkg::axil_data_t wdata;
		sema_pkg::axil_data_t exp;
	} row_t;

	localparam int NROWS = 16;
	localparam int TMO = 50;

	logic clk_i;
	logic arst_n_i;
	logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
	logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
	sema_pkg::axil_addr_t s_awaddr_i, s_araddr_i;
	sema_pkg::axil_data_t s_wdata_i, s_rdata_o;

	row_t tbl [NROWS];
	// Reference counts, only entries that were loaded are meaningful
	sema_pkg::sema_cnt_t model [`SEMA_COUNT];
	int seed = 32'h2d1a_67be;
	int data_errs = 0;
	int tmo_errs = 0;

	sema_clk_gen u_clk (.clk_o(clk_i), .arst_n_o(arst_n_i));

	sema_top u_dut (.*);

	// Level of the ready or valid that a wait is watching
	function automatic logic chan_up(input int ch);
		case (ch)
			// A write needs both the address and the data ready
			0: return s_awready_o && s_wready_o;
			1: return s_arready_o;
			2: return s_bvalid_o;
			default: return s_rvalid_o;
		endcase
	endfunction

	// Sampled at the falling edge, half a cycle clear of the drive point
	task automatic wait_chan(input int ch, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!chan_up(ch) && n < TMO);
		assert (chan_up(ch)) else begin
			$display("Timeout at %0t ns: the %s handshake did not complete in %0d cycles",
				$time, what, TMO);
			tmo_errs++;
		end
	endtask

	task automatic check_rdata(input sema_pkg::axil_data_t exp);
		assert (s_rvalid_o && s_rdata_o === exp) else begin
			$display("error at %0t ns: s_rdata_o expected %h, actual %h", $time, exp, s_rdata_o);
			data_errs++;
		end
	endtask

	// Ready stays low for 0 to 3 cycles, a read must hold its data meanwhile
	task automatic accept_resp(input logic is_wr, input sema_pkg::axil_data_t exp);
		int hold;
		hold = $random(seed) & 3;
		repeat (hold) begin
			@(negedge clk_i);
			if (!is_wr)
				check_rdata(exp);
		end
		@(posedge clk_i);
		#2;
		s_bready_i = is_wr;
		s_rready_i = !is_wr;
		@(posedge clk_i);
		#2;
		s_bready_i = 1'b0;
		s_rready_i = 1'b0;
	endtask

	task automatic axil_write(input sema_pkg::axil_addr_t addr, input sema_pkg::axil_data_t data);
		s_awaddr_i = addr;
		s_wdata_i = data;
		s_awvalid_i = 1'b1;
		s_wvalid_i = 1'b1;
		wait_chan(0, "write address and data");
		@(posedge clk_i);
		#2;
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		wait_chan(2, "write response");
		accept_resp(1'b1, '0);
	endtask

	task automatic axil_read(input sema_pkg::axil_addr_t addr, input sema_pkg::axil_data_t exp);
		s_araddr_i = addr;
		s_arvalid_i = 1'b1;
		wait_chan(1, "read address");
		@(posedge clk_i);
		#2;
		s_arvalid_i = 1'b0;
		wait_chan(3, "read data");
		check_rdata(exp);
		accept_resp(1'b0, exp);
	endtask

	initial begin
		int i;
		int r;
		int d;
		int cnt;
		int amt;
		sema_pkg::sema_idx_t idx;
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b0;
		s_awaddr_i = '0;
		s_araddr_i = '0;
		s_wdata_i = '0;

		// ============================================================
		// Directed table
		// ============================================================
		// Loads with junk in the upper data bits, then take, give and neighbors
		tbl[0] = '{1'b1, 13'h1100, 32'hdead_bea5, 32'h0};
		tbl[1] = '{1'b1, 13'h1110, 32'h0000_0003, 32'h0};
		tbl[2] = '{1'b1, 13'h1120, 32'h1234_56fa, 32'h0};
		tbl[3] = '{1'b1, 13'h1130, 32'hffff_ff40, 32'h0};
		tbl[4] = '{1'b0, 13'h1100, 32'h0, 32'h0000_00a5};
		// Take 5 from 3 returns 3 and stops at zero
		tbl[5] = '{1'b0, 13'h0115, 32'h0, 32'h0000_0003};
		tbl[6] = '{1'b0, 13'h1110, 32'h0, 32'h0000_0000};
		// Give 15 to 250 stops at 255
		tbl[7] = '{1'b1, 13'h012f, 32'hffff_ffff, 32'h0};
		tbl[8] = '{1'b0, 13'h1120, 32'h0, 32'h0000_00ff};
		// Give 0 changes nothing
		tbl[9] = '{1'b1, 13'h0130, 32'h0, 32'h0};
		tbl[10] = '{1'b0, 13'h1130, 32'h0, 32'h0000_0040};
		tbl[11] = '{1'b0, 13'h0137, 32'h0, 32'h0000_0040};
		tbl[12] = '{1'b0, 13'h1130, 32'h0, 32'h0000_0039};
		tbl[13] = '{1'b0, 13'h1100, 32'h0, 32'h0000_00a5};
		tbl[14] = '{1'b0, 13'h1110, 32'h0, 32'h0000_0000};
		tbl[15] = '{1'b0, 13'h1120, 32'h0, 32'h0000_00ff};

		i = 0;
		while (!arst_n_i && i < 20) begin
			@(posedge clk_i);
			i++;
		end
		#2;
		assert (arst_n_i) else begin
			$display("Reset was never released");
			tmo_errs++;
		end

		for (i = 0; i < NROWS; i++) begin
			if (tbl[i].wr)
				axil_write(tbl[i].addr, tbl[i].wdata);
			else
				axil_read(tbl[i].addr, tbl[i].exp);
		end

		// ============================================================
		// Random phase on indices 0x40 to 0x4f
		// ============================================================
		for (i = 0; i < 16; i++) begin
			d = $random(seed);
			idx = sema_pkg::sema_idx_t'(64 + i);
			model[idx] = d[7:0];
			axil_write({1'b1, idx, 4'h0}, d);
		end
		for (i = 0; i < 200; i++) begin
			r = $random(seed);
			d = $random(seed);
			idx = {4'h4, r[3:0]};
			cnt = int'(model[idx]);
			amt = int'(r[7:4]);
			case (r[9:8])
				2'd0: begin
					model[idx] = sema_pkg::sema_cnt_t'((cnt > amt) ? cnt - amt : 0);
					axil_read({1'b0, idx, r[7:4]}, 32'(cnt));
				end
				2'd1: begin
					model[idx] = sema_pkg::sema_cnt_t'((cnt + amt > 255) ? 255 : cnt + amt);
					axil_write({1'b0, idx, r[7:4]}, d);
				end
				2'd2: axil_read({1'b1, idx, r[7:4]}, 32'(cnt));
				default: begin
					model[idx] = d[7:0];
					// A peek of the same index raised together with the load sees the new value
					if (r[20:18] == 3'd0) begin
						s_araddr_i = {1'b1, idx, 4'h0};
						s_arvalid_i = 1'b1;
					end
					axil_write({1'b1, idx, r[7:4]}, d);
					if (r[20:18] == 3'd0)
						axil_read({1'b1, idx, 4'h0}, 32'(model[idx]));
				end
			endcase
		end

		$display("Errors: %0d data, %0d timeout, %0d assertion",
			data_errs, tmo_errs, u_dut.u_slave.u_chk.fail_cnt);
		if (data_errs + tmo_errs + u_dut.u_slave.u_chk.fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- sim/sema_chk.sv
`timescale 1ns/1ns

module sema_chk (
	input logic                 clk_i,
	input logic                 arst_n_i,
	input logic                 s_awready_o,
	input logic                 s_arready_o,
	input logic                 s_bvalid_o,
	input logic                 s_bready_i,
	input logic                 s_rvalid_o,
	input logic                 s_rready_i,
	input sema_pkg::axil_data_t s_rdata_o,
	input sema_pkg::sema_req_t  req_o,
	input sema_pkg::sema_rsp_t  rsp_i
);

	// Tally of failed properties
	int fail_cnt = 0;

	// Set once the first transaction after reset has been accepted
	logic seen_acc_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			seen_acc_q <= 1'b0;
		else if (s_awready_o || s_arready_o)
			seen_acc_q <= 1'b1;
	end

	task automatic count_failure(input string what);
		$error("%s", what);
		fail_cnt++;
	endtask

	// ============================================================
	// Properties
	// ============================================================

	// Responses hold, with stable data, until the master takes them
	a_b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o) else count_failure("bvalid dropped early");
	a_r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
		else count_failure("rvalid or rdata changed before rready");

	// The array answers every request pulse exactly one cycle later
	a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rsp_i.valid == $past(req_o.valid)) else count_failure("response pulse out of step");

	a_rdy_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(s_awready_o && s_arready_o)) else count_failure("awready and arready both high");

	// Nothing is presented before the first accepted transaction
	a_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!seen_acc_q |-> !s_bvalid_o && !s_rvalid_o && !req_o.valid)
		else count_failure("valid output high before any transaction");

endmodule

bind sema_axil_slave sema_chk u_chk (.*);

//--- sim/sema_clk_gen.sv
`timescale 1ns/1ns

module sema_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Reset is held low for ten rising edges, then released off the edge
	initial begin
		arst_n_o = 1'b0;
		repeat (10) @(posedge clk_o);
		#2;
		arst_n_o = 1'b1;
	end

endmodule

//--- verilog/sema_top.sv
`timescale 1ns/1ns

module sema_top (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 s_awvalid_i,
	output logic                 s_awready_o,
	input  sema_pkg::axil_addr_t s_awaddr_i,
	input  logic                 s_wvalid_i,
	output logic                 s_wready_o,
	input  sema_pkg::axil_data_t s_wdata_i,
	output logic                 s_bvalid_o,
	input  logic                 s_bready_i,
	input  logic                 s_arvalid_i,
	output logic                 s_arready_o,
	input  sema_pkg::axil_addr_t s_araddr_i,
	output logic                 s_rvalid_o,
	input  logic                 s_rready_i,
	output sema_pkg::axil_data_t s_rdata_o
);

	// Request and response between the bus front end and the storage
	sema_pkg::sema_req_t req;
	sema_pkg::sema_rsp_t rsp;

	// Bus front end, one transaction at a time
	sema_axil_slave u_slave (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_awaddr_i  (s_awaddr_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_wdata_i   (s_wdata_i),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_araddr_i  (s_araddr_i),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.s_rdata_o   (s_rdata_o),
		.req_o       (req),
		.rsp_i       (rsp)
	);

	// Count storage and saturating update
	sema_array u_array (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (req),
		.rsp_o    (rsp)
	);

endmodule

//--- verilog/sema_array.sv
`timescale 1ns/1ns
`include "sema_macros.svh"

module sema_array (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  sema_pkg::sema_req_t req_i,
	output sema_pkg::sema_rsp_t rsp_o
);

	// ============================================================
	// Storage
	// ============================================================

	// One count per semaphore, contents are undefined until loaded
	sema_pkg::sema_cnt_t mem_q [`SEMA_COUNT];

	// Count addressed by the current request
	sema_pkg::sema_cnt_t cur_cnt;
	// Value that goes back into the same entry
	sema_pkg::sema_cnt_t new_cnt;

	// One extra bit catches the carry or the borrow
	logic [`SEMA_CNT_W:0] amt_ext;
	logic [`SEMA_CNT_W:0] inc_sum;
	logic [`SEMA_CNT_W:0] dec_diff;

	// Response registers
	logic                rsp_vld_q;
	sema_pkg::sema_cnt_t old_cnt_q;

	assign cur_cnt = mem_q[req_i.idx];

	// ============================================================
	// Saturating arithmetic
	// ============================================================

	// Step amount widened to the arithmetic width
	assign amt_ext  = {{(`SEMA_CNT_W + 1 - `SEMA_AMT_W){1'b0}}, req_i.amt};
	assign inc_sum  = {1'b0, cur_cnt} + amt_ext;
	assign dec_diff = {1'b0, cur_cnt} - amt_ext;

	always_comb begin
		case (req_i.op)
			// Borrow out of the top bit means the take went below zero
			sema_pkg::SEMA_TAKE: begin
				if (dec_diff[`SEMA_CNT_W])
					new_cnt = '0;
				else
					new_cnt = dec_diff[`SEMA_CNT_W-1:0];
			end
			// Carry out means the give passed the top, so pin at all ones
			sema_pkg::SEMA_GIVE: begin
				if (inc_sum[`SEMA_CNT_W])
					new_cnt = '1;
				else
					new_cnt = inc_sum[`SEMA_CNT_W-1:0];
			end
			// A peek writes the same value back
			sema_pkg::SEMA_PEEK: new_cnt = cur_cnt;
			// Direct write replaces the count outright
			sema_pkg::SEMA_LOAD: new_cnt = req_i.load_val;
			default:             new_cnt = cur_cnt;
		endcase
	end

	// ============================================================
	// Read-modify-write
	// ============================================================

	// The old value is sampled and the new one stored on the same edge
	// so no other access can fall between the read and the write back
	always_ff @(posedge clk_i) begin
		if (req_i.valid) begin
			mem_q[req_i.idx] <= new_cnt;
			old_cnt_q        <= cur_cnt;
		end
	end

	// Response pulse follows each request by exactly one cycle
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			rsp_vld_q <= 1'b0;
		else
			rsp_vld_q <= req_i.valid;
	end

	assign rsp_o = '{
		valid:   rsp_vld_q,
		old_cnt: old_cnt_q
	};

endmodule

//--- verilog/sema_axil_slave.sv
`timescale 1ns/1ns
`include "sema_macros.svh"

module sema_axil_slave (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	// Write address and write data channels
	input  logic                 s_awvalid_i,
	output logic                 s_awready_o,
	input  sema_pkg::axil_addr_t s_awaddr_i,
	input  logic                 s_wvalid_i,
	output logic                 s_wready_o,
	input  sema_pkg::axil_data_t s_wdata_i,
	// Write response channel, always OKAY
	output logic                 s_bvalid_o,
	input  logic                 s_bready_i,
	// Read address and read data channels
	input  logic                 s_arvalid_i,
	output logic                 s_arready_o,
	input  sema_pkg::axil_addr_t s_araddr_i,
	output logic                 s_rvalid_o,
	input  logic                 s_rready_i,
	output sema_pkg::axil_data_t s_rdata_o,
	// Request to and response from the semaphore array
	output sema_pkg::sema_req_t  req_o,
	input  sema_pkg::sema_rsp_t  rsp_i
);

	sema_pkg::slv_state_e state_q;
	sema_pkg::slv_state_e state_d;

	logic wr_hs;
	logic rd_hs;
	logic op_is_wr;

	// Address of the transaction being accepted, write takes priority
	sema_pkg::axil_addr_t acc_addr;
	sema_pkg::sema_op_e   acc_op;

	// Request registers, the valid bit is the only control part
	logic                req_vld_q;
	sema_pkg::sema_op_e  op_q;
	sema_pkg::sema_idx_t idx_q;
	sema_pkg::sema_amt_t amt_q;
	sema_pkg::sema_cnt_t load_q;

	// Old count returned on the R channel
	sema_pkg::sema_cnt_t rdata_q;

	// ============================================================
	// Handshakes
	// ============================================================

	// AW and W are taken together so a write always has both halves
	assign s_awready_o = (state_q == sema_pkg::ST_IDLE) && s_awvalid_i && s_wvalid_i;
	assign s_wready_o  = s_awready_o;

	// A read waits while any half of a write is presented
	assign s_arready_o = (state_q == sema_pkg::ST_IDLE) && s_arvalid_i
		&& !s_awvalid_i && !s_wvalid_i;

	assign wr_hs = s_awready_o;
	assign rd_hs = s_arready_o;

	// Bit 12 picks direct access, the direction picks the pair member
	assign acc_addr = wr_hs ? s_awaddr_i : s_araddr_i;
	always_comb begin
		if (acc_addr[`SEMA_ADDR_W-1])
			acc_op = wr_hs ? sema_pkg::SEMA_LOAD : sema_pkg::SEMA_PEEK;
		else
			acc_op = wr_hs ? sema_pkg::SEMA_GIVE : sema_pkg::SEMA_TAKE;
	end

	// GIVE and LOAD came in as writes and answer on the B channel
	assign op_is_wr = (op_q == sema_pkg::SEMA_GIVE) || (op_q == sema_pkg::SEMA_LOAD);

	// ============================================================
	// FSM
	// ============================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			sema_pkg::ST_IDLE: if (wr_hs || rd_hs) state_d = sema_pkg::ST_EXEC;
			// The array answers one cycle after the request pulse
			sema_pkg::ST_EXEC: begin
				if (rsp_i.valid)
					state_d = op_is_wr ? sema_pkg::ST_WRSP : sema_pkg::ST_RRSP;
			end
			sema_pkg::ST_WRSP: if (s_bready_i) state_d = sema_pkg::ST_IDLE;
			sema_pkg::ST_RRSP: if (s_rready_i) state_d = sema_pkg::ST_IDLE;
			default: state_d = sema_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= sema_pkg::ST_IDLE;
			req_vld_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Single pulse, raised only on the accepting edge
			req_vld_q <= wr_hs || rd_hs;
		end
	end

	// Request payload is latched once per accepted transaction
	always_ff @(posedge clk_i) begin
		if (wr_hs || rd_hs) begin
			op_q   <= acc_op;
			idx_q  <= acc_addr[`SEMA_AMT_W +: `SEMA_IDX_W];
			amt_q  <= acc_addr[`SEMA_AMT_W-1:0];
			load_q <= s_wdata_i[`SEMA_CNT_W-1:0];
		end
	end

	// Read data is held through any R channel back-pressure
	always_ff @(posedge clk_i) begin
		if ((state_q == sema_pkg::ST_EXEC) && rsp_i.valid && !op_is_wr)
			rdata_q <= rsp_i.old_cnt;
	end

	assign req_o = '{
		valid:    req_vld_q,
		op:       op_q,
		idx:      idx_q,
		amt:      amt_q,
		load_val: load_q
	};

	assign s_bvalid_o = (state_q == sema_pkg::ST_WRSP);
	assign s_rvalid_o = (state_q == sema_pkg::ST_RRSP);
	// Count sits in the low byte, upper bits read as zero
	assign s_rdata_o  = sema_pkg::axil_data_t'(rdata_q);

endmodule

//--- verilog/sema_pkg.sv
`include "sema_macros.svh"

package sema_pkg;

	// Vector types for the fields that carry a meaning
	typedef logic [`SEMA_IDX_W-1:0]  sema_idx_t;
	typedef logic [`SEMA_CNT_W-1:0]  sema_cnt_t;
	typedef logic [`SEMA_AMT_W-1:0]  sema_amt_t;
	typedef logic [`SEMA_ADDR_W-1:0] axil_addr_t;
	typedef logic [`SEMA_DATA_W-1:0] axil_data_t;

	// Operation decoded from the mode bit and the bus direction
	// TAKE and PEEK come from reads, GIVE and LOAD from writes
	typedef enum logic [1:0] {
		SEMA_TAKE,
		SEMA_GIVE,
		SEMA_PEEK,
		SEMA_LOAD
	} sema_op_e;

	// One atomic operation sent from the bus front end to the storage
	typedef struct packed {
		logic      valid;
		sema_op_e  op;
		sema_idx_t idx;
		sema_amt_t amt;
		sema_cnt_t load_val;
	} sema_req_t;

	// Answer from the storage, one cycle after the request
	typedef struct packed {
		logic      valid;
		sema_cnt_t old_cnt;
	} sema_rsp_t;

	// Bus front end states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXEC,
		ST_WRSP,
		ST_RRSP
	} slv_state_e;

endpackage

//--- include/sema_macros.svh
`ifndef SEMA_MACROS_SVH
`define SEMA_MACROS_SVH

// ============================================================
// Semaphore bank geometry
// ============================================================

// Number of semaphores in the bank, one per index value
`define SEMA_COUNT 256
// Index field taken from address bits 11:4
`define SEMA_IDX_W 8
// Every semaphore holds an eight-bit count
`define SEMA_CNT_W 8
// Step amount taken from address bits 3:0
`define SEMA_AMT_W 4

// ============================================================
// AXI4-Lite widths
// ============================================================

// Bit 12 selects direct access, bits 11:0 carry index and amount
`define SEMA_ADDR_W 13
`define SEMA_DATA_W 32

`endif
